/* Makefile */
VERILATOR ?= verilator
TOP       ?= feature_engine_tb
FILELIST  ?= feature_engine_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= sim failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* feature_engine_top.f */
sparse_pkg.sv
logic/row_address_counter.sv
logic/dram_access_ctrl.sv
logic/dram_row_packer.sv
logic/lane_row_memory.sv
logic/lane_dot_product.sv
logic/feature_engine_top.sv
tb/tb_clock_gen.sv
tb/feature_engine_tb.sv

/* logic/dram_access_ctrl.sv */
`timescale 1ns/1ps

module dram_access_ctrl (
    input  logic                     clk_i,
    input  logic                     rd_weight_rst,
    input  logic                     start_i,
    input  sparse_pkg::region_t      weight_region_i,
    input  sparse_pkg::region_t      feature_region_i,
    input  logic                     last_i,
    output logic                     cnt_load_o,
    output logic                     cnt_step_o,
    output sparse_pkg::dram_addr_t   cnt_start_o,
    output sparse_pkg::dram_addr_t   cnt_finish_o,
    output logic                     word_valid_o,
    output sparse_pkg::load_target_e target_o,
    output logic                     rd_en_o,
    output logic                     busy_o,
    output logic                     done_o
);

    sparse_pkg::engine_state_e state_q;
    sparse_pkg::engine_state_e state_d;
    sparse_pkg::region_t       weight_q;
    sparse_pkg::region_t       feature_q;
    sparse_pkg::dram_addr_t    weight_len;
    sparse_pkg::dram_addr_t    rows_m1;
    logic [1:0]                wait_q;
    logic [1:0]                wait_d;
    logic [1:0]                rd_pipe_q;
    logic                      issue;
    logic                      done_d;

    function automatic sparse_pkg::dram_addr_t region_words(input sparse_pkg::region_t r);
        return r.finish_addr - r.start_addr + 1'b1;
    endfunction

    // rows per region, both regions are the same size
    assign weight_len = region_words(weight_q);
    assign rows_m1 = sparse_pkg::dram_addr_t'(weight_len / sparse_pkg::WORDS_PER_ROW) - 1'b1;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        wait_d       = (wait_q != 2'd0) ? wait_q - 2'd1 : 2'd0;
        cnt_load_o   = 1'b0;
        cnt_step_o   = 1'b0;
        cnt_start_o  = '0;
        cnt_finish_o = rows_m1;
        rd_en_o      = 1'b0;
        issue        = 1'b0;
        done_d       = 1'b0;

        case (state_q)
            sparse_pkg::IDLE: begin
                cnt_start_o  = weight_region_i.start_addr;
                cnt_finish_o = weight_region_i.finish_addr;
                if (start_i) begin
                    cnt_load_o = 1'b1;
                    state_d    = sparse_pkg::LOAD_WEIGHT;
                end
            end
            sparse_pkg::LOAD_WEIGHT: begin
                issue        = 1'b1;
                cnt_start_o  = feature_q.start_addr;
                cnt_finish_o = feature_q.finish_addr;
                // one drain cycle before the feature walk
                if (last_i) begin
                    cnt_load_o = 1'b1;
                    wait_d     = 2'd1;
                    state_d    = sparse_pkg::LOAD_FEATURE;
                end else begin
                    cnt_step_o = 1'b1;
                end
            end
            sparse_pkg::LOAD_FEATURE: begin
                if (wait_q == 2'd0) begin
                    issue = 1'b1;
                    // counter reloaded as row index 0..R-1
                    if (last_i) begin
                        cnt_load_o = 1'b1;
                        wait_d     = 2'd2;
                        state_d    = sparse_pkg::COMPUTE;
                    end else begin
                        cnt_step_o = 1'b1;
                    end
                end
            end
            sparse_pkg::COMPUTE: begin
                // the wait lets the last feature row reach memory
                if (wait_q == 2'd0) begin
                    rd_en_o = 1'b1;
                    if (last_i) begin
                        state_d = sparse_pkg::FINISH;
                    end else begin
                        cnt_step_o = 1'b1;
                    end
                end
            end
            sparse_pkg::FINISH: begin
                // last result is on the output this cycle
                if (rd_pipe_q[1] && !rd_pipe_q[0]) begin
                    done_d  = 1'b1;
                    state_d = sparse_pkg::IDLE;
                end
            end
            default: begin
                state_d = sparse_pkg::IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q      <= sparse_pkg::IDLE;
            wait_q       <= 2'd0;
            rd_pipe_q    <= 2'b00;
            word_valid_o <= 1'b0;
            target_o     <= sparse_pkg::TARGET_WEIGHT;
            done_o       <= 1'b0;
        end else begin
            state_q      <= state_d;
            wait_q       <= wait_d;
            rd_pipe_q    <= {rd_pipe_q[0], rd_en_o};
            word_valid_o <= issue;
            done_o       <= done_d;
            // data for an address returns one cycle later
            if (issue) begin
                target_o <= (state_q == sparse_pkg::LOAD_FEATURE) ?
                            sparse_pkg::TARGET_FEATURE : sparse_pkg::TARGET_WEIGHT;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == sparse_pkg::IDLE && start_i) begin
            weight_q  <= weight_region_i;
            feature_q <= feature_region_i;
        end
    end

    assign busy_o = (state_q != sparse_pkg::IDLE);

    // region shape on an accepted start
    a_whole_rows : assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        (start_i && !busy_o) |->
            (region_words(weight_region_i) % sparse_pkg::WORDS_PER_ROW == 0) &&
            (region_words(feature_region_i) % sparse_pkg::WORDS_PER_ROW == 0)
    );

    a_equal_rows : assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        (start_i && !busy_o) |->
            region_words(weight_region_i) == region_words(feature_region_i)
    );

endmodule

/* logic/dram_row_packer.sv */
`timescale 1ns/1ps

module dram_row_packer #(
    parameter int MEM_ADDR_WIDTH = sparse_pkg::MEM_ADDR_WIDTH
) (
    input  logic                      clk_i,
    input  logic                      rd_weight_rst,
    input  logic                      word_valid_i,
    input  sparse_pkg::load_target_e  target_i,
    input  sparse_pkg::dram_word_t    mem_data_i,
    output sparse_pkg::lane_row_t     row_o,
    output logic [MEM_ADDR_WIDTH-1:0] wr_addr_o,
    output logic                      weight_wr_o,
    output logic                      feature_wr_o
);

    localparam int CNT_WIDTH = $clog2(sparse_pkg::WORDS_PER_ROW);

    logic [sparse_pkg::ROW_WIDTH-1:0] shift_q;
    logic [CNT_WIDTH-1:0]             word_cnt_q;
    logic [MEM_ADDR_WIDTH-1:0]        row_idx_q;
    logic [MEM_ADDR_WIDTH-1:0]        row_sel;
    sparse_pkg::load_target_e         target_q;
    logic                             wr_q;

    // a new destination starts again at row 0
    assign row_sel = (target_i != target_q) ? '0 : row_idx_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_cnt_q <= '0;
            row_idx_q  <= '0;
            target_q   <= sparse_pkg::TARGET_WEIGHT;
            wr_q       <= 1'b0;
        end else begin
            wr_q <= 1'b0;
            if (word_valid_i) begin
                target_q <= target_i;
                if (word_cnt_q == CNT_WIDTH'(sparse_pkg::WORDS_PER_ROW - 1)) begin
                    word_cnt_q <= '0;
                    wr_q       <= 1'b1;
                    row_idx_q  <= row_sel + 1'b1;
                end else begin
                    word_cnt_q <= word_cnt_q + 1'b1;
                    row_idx_q  <= row_sel;
                end
            end
        end
    end

    // words enter at the top, so the first word ends in lanes 0 to 3
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            shift_q <= {mem_data_i, shift_q[sparse_pkg::ROW_WIDTH-1:sparse_pkg::DRAM_DATA_WIDTH]};
            if (word_cnt_q == CNT_WIDTH'(sparse_pkg::WORDS_PER_ROW - 1)) begin
                wr_addr_o <= row_sel;
            end
        end
    end

    assign row_o        = shift_q;
    assign weight_wr_o  = wr_q && (target_q == sparse_pkg::TARGET_WEIGHT);
    assign feature_wr_o = wr_q && (target_q == sparse_pkg::TARGET_FEATURE);

endmodule

/* logic/feature_engine_top.sv */
`timescale 1ns/1ps

module feature_engine_top #(
    parameter int MEM_ADDR_WIDTH = sparse_pkg::MEM_ADDR_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   rd_weight_rst,
    input  logic                   start_i,
    input  sparse_pkg::region_t    weight_region_i,
    input  sparse_pkg::region_t    feature_region_i,
    input  sparse_pkg::dram_word_t mem_data_i,
    output sparse_pkg::dram_addr_t dram_rd_address_o,
    output sparse_pkg::acc_t       final_output_o,
    output logic                   result_valid_o,
    output logic                   busy_o,
    output logic                   done_o
);

    logic                      cnt_load;
    logic                      cnt_step;
    logic                      cnt_last;
    sparse_pkg::dram_addr_t    cnt_start;
    sparse_pkg::dram_addr_t    cnt_finish;
    sparse_pkg::dram_addr_t    cnt_value;
    logic                      word_valid;
    sparse_pkg::load_target_e  target;
    logic                      rd_en;
    sparse_pkg::lane_row_t     packed_row;
    logic [MEM_ADDR_WIDTH-1:0] wr_addr;
    logic [MEM_ADDR_WIDTH-1:0] rd_addr;
    logic                      weight_wr;
    logic                      feature_wr;
    sparse_pkg::lane_row_t     weight_row;
    sparse_pkg::lane_row_t     feature_row;

    // counter doubles as DRAM address and row index
    assign dram_rd_address_o = cnt_value;
    assign rd_addr           = cnt_value[MEM_ADDR_WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////
    // control and address walk
    //////////////////////////////////////////////////////////////////////

    dram_access_ctrl dram_access_controller (
        .clk_i           (clk_i),
        .rd_weight_rst   (rd_weight_rst),
        .start_i         (start_i),
        .weight_region_i (weight_region_i),
        .feature_region_i(feature_region_i),
        .last_i          (cnt_last),
        .cnt_load_o      (cnt_load),
        .cnt_step_o      (cnt_step),
        .cnt_start_o     (cnt_start),
        .cnt_finish_o    (cnt_finish),
        .word_valid_o    (word_valid),
        .target_o        (target),
        .rd_en_o         (rd_en),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    row_address_counter #(
        .COUNT_WIDTH(sparse_pkg::DRAM_ADDR_WIDTH)
    ) address_counter (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .load_i        (cnt_load),
        .step_i        (cnt_step),
        .start_value_i (cnt_start),
        .finish_value_i(cnt_finish),
        .count_o       (cnt_value),
        .last_o        (cnt_last)
    );

    //////////////////////////////////////////////////////////////////////
    // load path and compute
    //////////////////////////////////////////////////////////////////////

    dram_row_packer #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) row_packer (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .word_valid_i (word_valid),
        .target_i     (target),
        .mem_data_i   (mem_data_i),
        .row_o        (packed_row),
        .wr_addr_o    (wr_addr),
        .weight_wr_o  (weight_wr),
        .feature_wr_o (feature_wr)
    );

    lane_row_memory #(
        .ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) weight_memory (
        .clk_i    (clk_i),
        .wr_en_i  (weight_wr),
        .wr_addr_i(wr_addr),
        .rd_addr_i(rd_addr),
        .wr_data_i(packed_row),
        .rd_en_i  (rd_en),
        .rd_data_o(weight_row)
    );

    lane_row_memory #(
        .ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) feature_memory (
        .clk_i    (clk_i),
        .wr_en_i  (feature_wr),
        .wr_addr_i(wr_addr),
        .rd_addr_i(rd_addr),
        .wr_data_i(packed_row),
        .rd_en_i  (rd_en),
        .rd_data_o(feature_row)
    );

    lane_dot_product dot_product (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .valid_i      (rd_en),
        .weight_row_i (weight_row),
        .feature_row_i(feature_row),
        .result_o     (final_output_o),
        .valid_o      (result_valid_o)
    );

endmodule

/* logic/lane_dot_product.sv */
`timescale 1ns/1ps

module lane_dot_product (
    input  logic                  clk_i,
    input  logic                  rd_weight_rst,
    input  logic                  valid_i,
    input  sparse_pkg::lane_row_t weight_row_i,
    input  sparse_pkg::lane_row_t feature_row_i,
    output sparse_pkg::acc_t      result_o,
    output logic                  valid_o
);

    logic             operand_valid_q;
    sparse_pkg::acc_t dot_sum;

    // lanes sign extended to ACC_WIDTH, the sum wraps at that width
    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < sparse_pkg::LANES; i++) begin
            dot_sum = dot_sum + sparse_pkg::acc_t'(weight_row_i[i]) *
                                sparse_pkg::acc_t'(feature_row_i[i]);
        end
    end

    // operand_valid_q marks the cycle the memory rows sit on the inputs
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            operand_valid_q <= 1'b0;
            valid_o         <= 1'b0;
        end else begin
            operand_valid_q <= valid_i;
            valid_o         <= operand_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (operand_valid_q) begin
            result_o <= dot_sum;
        end
    end

endmodule

/* logic/lane_row_memory.sv */
`timescale 1ns/1ps

module lane_row_memory #(
    parameter int ADDR_WIDTH = sparse_pkg::MEM_ADDR_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    input  sparse_pkg::lane_row_t wr_data_i,
    input  logic                  rd_en_i,
    output sparse_pkg::lane_row_t rd_data_o
);

    sparse_pkg::lane_row_t mem [2**ADDR_WIDTH];

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* logic/row_address_counter.sv */
`timescale 1ns/1ps

module row_address_counter #(
    parameter int COUNT_WIDTH = sparse_pkg::DRAM_ADDR_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   rd_weight_rst,
    input  logic                   load_i,
    input  logic                   step_i,
    input  logic [COUNT_WIDTH-1:0] start_value_i,
    input  logic [COUNT_WIDTH-1:0] finish_value_i,
    output logic [COUNT_WIDTH-1:0] count_o,
    output logic                   last_o
);

    logic [COUNT_WIDTH-1:0] finish_q;

    // load wins over step
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            count_o  <= '0;
            finish_q <= '0;
        end else if (load_i) begin
            count_o  <= start_value_i;
            finish_q <= finish_value_i;
        end else if (step_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign last_o = (count_o == finish_q);

    // the controller must stop walking once the finish value is reached
    a_no_step_past_finish : assert property (
        @(posedge clk_i) disable iff (rd_weight_rst)
        step_i |-> !last_o
    );

endmodule

/* sparse_pkg.sv */
package sparse_pkg;

    //////////////////////////////////////////////////////////////////////
    // lane and bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int LANES = 16;
    localparam int I_WIDTH = 8;
    localparam int F_WIDTH = 8;
    localparam int ACC_WIDTH = I_WIDTH + F_WIDTH;

    localparam int DRAM_DATA_WIDTH = 32;
    localparam int DRAM_ADDR_WIDTH = 18;

    // one memory row holds all lanes
    localparam int ROW_WIDTH = LANES * I_WIDTH;
    localparam int WORDS_PER_ROW = ROW_WIDTH / DRAM_DATA_WIDTH;

    // default depth of the lane memories, 64 rows
    localparam int MEM_ADDR_WIDTH = 6;

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [I_WIDTH-1:0] lane_t;

    // lane 0 sits in the lowest byte
    typedef lane_t [LANES-1:0] lane_row_t;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;
    typedef logic [DRAM_DATA_WIDTH-1:0] dram_word_t;
    typedef logic [DRAM_ADDR_WIDTH-1:0] dram_addr_t;

    // inclusive word range in DRAM
    typedef struct packed {
        dram_addr_t start_addr;
        dram_addr_t finish_addr;
    } region_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WEIGHT,
        LOAD_FEATURE,
        COMPUTE,
        FINISH
    } engine_state_e;

    typedef enum logic {
        TARGET_WEIGHT,
        TARGET_FEATURE
    } load_target_e;

endpackage

/* tb/feature_engine_tb.sv */
`timescale 1ns/1ps

module feature_engine_tb;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES = 3;
    localparam int SEED = 94;
    localparam int DRAM_INDEX_WIDTH = 12;
    localparam int DRAM_DEPTH = 2**DRAM_INDEX_WIDTH;
    localparam int MAX_ROWS = 2**sparse_pkg::MEM_ADDR_WIDTH;
    localparam int LANES_PER_WORD = sparse_pkg::DRAM_DATA_WIDTH / sparse_pkg::I_WIDTH;
    localparam int JOB_OVERHEAD = 24;
    localparam int SETTLE_CYCLES = 4;
    localparam int IDLE_CHECK_CYCLES = 8;
    localparam int WATCHDOG_MARGIN = 100;

    logic                   clk;
    logic                   rd_weight_rst;
    logic                   start;
    sparse_pkg::region_t    weight_region;
    sparse_pkg::region_t    feature_region;
    sparse_pkg::dram_word_t mem_data;
    sparse_pkg::dram_addr_t dram_rd_address;
    sparse_pkg::acc_t       final_output;
    logic                   result_valid;
    logic                   busy;
    logic                   done;

    sparse_pkg::dram_word_t dram_model [DRAM_DEPTH];
    sparse_pkg::lane_row_t  weight_rows [MAX_ROWS];
    sparse_pkg::lane_row_t  feature_rows [MAX_ROWS];
    sparse_pkg::acc_t       results [$];
    int                     done_count;
    int                     results_at_done;
    int                     mismatch_count;
    int                     failure_count;

    tb_clock_gen #(
        .PERIOD_NS(CLK_PERIOD_NS)
    ) clock_gen (
        .clk_o(clk)
    );

    feature_engine_top #(
        .MEM_ADDR_WIDTH(sparse_pkg::MEM_ADDR_WIDTH)
    ) UUT (
        .clk_i            (clk),
        .rd_weight_rst    (rd_weight_rst),
        .start_i          (start),
        .weight_region_i  (weight_region),
        .feature_region_i (feature_region),
        .mem_data_i       (mem_data),
        .dram_rd_address_o(dram_rd_address),
        .final_output_o   (final_output),
        .result_valid_o   (result_valid),
        .busy_o           (busy),
        .done_o           (done)
    );

    //////////////////////////////////////////////////////////////////////
    // DRAM model and result monitor
    //////////////////////////////////////////////////////////////////////

    // word for this cycle's address shows up next cycle
    always @(posedge clk) begin
        mem_data <= dram_model[dram_rd_address[DRAM_INDEX_WIDTH-1:0]];
    end

    // falling edge, outputs are settled here
    always @(negedge clk) begin
        if (result_valid) begin
            results.push_back(final_output);
        end
        if (done) begin
            done_count++;
            results_at_done = results.size();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////////////////////////

    function automatic int job_budget(input int rows);
        return 2 * sparse_pkg::WORDS_PER_ROW * rows + rows + JOB_OVERHEAD;
    endfunction

    // signed lane products, low ACC_WIDTH bits kept
    function automatic sparse_pkg::acc_t reference_dot(input sparse_pkg::lane_row_t w,
                                                       input sparse_pkg::lane_row_t f);
        int sum;
        sum = 0;
        for (int i = 0; i < sparse_pkg::LANES; i++) begin
            sum += int'(w[i]) * int'(f[i]);
        end
        return sparse_pkg::acc_t'(sum);
    endfunction

    // byte b of word j carries lane 4*j+b
    function automatic sparse_pkg::dram_word_t pack_word(input sparse_pkg::lane_row_t row,
                                                         input int word_idx);
        sparse_pkg::dram_word_t word;
        word = '0;
        for (int b = 0; b < LANES_PER_WORD; b++) begin
            word[8*b +: 8] = row[LANES_PER_WORD*word_idx + b];
        end
        return word;
    endfunction

    function automatic sparse_pkg::region_t region_of(input int base, input int rows);
        sparse_pkg::region_t r;
        r.start_addr  = sparse_pkg::dram_addr_t'(base);
        r.finish_addr = sparse_pkg::dram_addr_t'(base + sparse_pkg::WORDS_PER_ROW * rows - 1);
        return r;
    endfunction

    task automatic check_result(input string name, input int row,
                                input sparse_pkg::acc_t expected, input sparse_pkg::acc_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s row %0d: expected %0d, actual %0d",
                     name, row, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // job helpers
    //////////////////////////////////////////////////////////////////////

    task automatic store_rows(input int weight_base, input int feature_base, input int rows);
        for (int r = 0; r < rows; r++) begin
            for (int j = 0; j < sparse_pkg::WORDS_PER_ROW; j++) begin
                dram_model[weight_base + sparse_pkg::WORDS_PER_ROW*r + j] =
                    pack_word(weight_rows[r], j);
                dram_model[feature_base + sparse_pkg::WORDS_PER_ROW*r + j] =
                    pack_word(feature_rows[r], j);
            end
        end
    endtask

    task automatic fill_random_rows(input int rows);
        for (int r = 0; r < rows; r++) begin
            for (int i = 0; i < sparse_pkg::LANES; i++) begin
                weight_rows[r][i]  = sparse_pkg::lane_t'($urandom);
                feature_rows[r][i] = sparse_pkg::lane_t'($urandom);
            end
        end
    endtask

    task automatic pulse_start(input sparse_pkg::region_t wr, input sparse_pkg::region_t fr);
        @(posedge clk);
        start          <= 1'b1;
        weight_region  <= wr;
        feature_region <= fr;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name, input int rows);
        int waited;
        waited = 0;
        while (done_count == 0 && waited < job_budget(rows)) begin
            @(posedge clk);
            waited++;
        end
        if (done_count == 0) begin
            $display("%s: the DUT gave no done pulse within %0d cycles", name, job_budget(rows));
            failure_count++;
        end
    endtask

    task automatic run_job(input string name, input int weight_base, input int feature_base,
                           input int rows, input bit extra_start);
        results.delete();
        done_count      = 0;
        results_at_done = 0;
        store_rows(weight_base, feature_base, rows);
        pulse_start(region_of(weight_base, rows), region_of(feature_base, rows));
        if (extra_start) begin
            // second start lands mid-load and must be dropped
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_flag({name, " busy at second start"}, 1'b1, busy);
            pulse_start(region_of(12'h800, rows), region_of(12'h900, rows));
        end
        wait_done(name, rows);
        repeat (SETTLE_CYCLES) @(posedge clk);
        check_count({name, " results"}, rows, results.size());
        check_count({name, " results before done"}, rows, results_at_done);
        check_count({name, " done pulses"}, 1, done_count);
        for (int r = 0; r < rows && r < results.size(); r++) begin
            check_result(name, r, reference_dot(weight_rows[r], feature_rows[r]), results[r]);
        end
        @(negedge clk);
        check_flag({name, " busy after done"}, 1'b0, busy);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_idle_after_reset();
        repeat (IDLE_CHECK_CYCLES) begin
            @(negedge clk);
            check_flag("idle busy", 1'b0, busy);
            check_flag("idle done", 1'b0, done);
            check_flag("idle result valid", 1'b0, result_valid);
        end
    endtask

    // weight lane i is i+1, feature lane i is i-8, dot product 272
    task automatic test_known_row();
        for (int i = 0; i < sparse_pkg::LANES; i++) begin
            weight_rows[0][i]  = sparse_pkg::lane_t'(i + 1);
            feature_rows[0][i] = sparse_pkg::lane_t'(i - 8);
        end
        run_job("known row", 12'h010, 12'h020, 1, 1'b0);
    endtask

    task automatic test_random_rows();
        fill_random_rows(8);
        run_job("random rows", 12'h100, 12'h180, 8, 1'b0);
    endtask

    // row 0 wraps 262144 to 0, row 1 wraps -260096 to 2048
    task automatic test_extreme_values();
        for (int i = 0; i < sparse_pkg::LANES; i++) begin
            weight_rows[0][i]  = -8'sd128;
            feature_rows[0][i] = -8'sd128;
            weight_rows[1][i]  = -8'sd128;
            feature_rows[1][i] = 8'sd127;
        end
        run_job("extreme values", 12'h040, 12'h060, 2, 1'b0);
    endtask

    task automatic test_busy_start_and_second_job();
        fill_random_rows(4);
        run_job("busy start", 12'h200, 12'h240, 4, 1'b1);
        fill_random_rows(3);
        run_job("second job", 12'h300, 12'h340, 3, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // watchdog and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        repeat (RESET_CYCLES + IDLE_CHECK_CYCLES + job_budget(1) + job_budget(8)
                + job_budget(2) + job_budget(4) + job_budget(3) + WATCHDOG_MARGIN) begin
            @(posedge clk);
        end
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rd_weight_rst   = 1'b1;
        start           = 1'b0;
        weight_region   = '0;
        feature_region  = '0;
        mem_data        = '0;
        done_count      = 0;
        results_at_done = 0;
        mismatch_count  = 0;
        failure_count   = 0;
        // background pattern, upper half is a scrambled copy of the address
        for (int a = 0; a < DRAM_DEPTH; a++) begin
            dram_model[a] = {16'(a) ^ 16'hc3a5, 16'(a)};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rd_weight_rst <= 1'b0;

        test_idle_after_reset();
        test_known_row();
        test_random_rows();
        test_extreme_values();
        test_busy_start_and_second_job();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // free running, first rising edge half a period in
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule
